/* source/isa_pkg.sv */
package isa_pkg;

	localparam int NUM_REGS = 64;

	// bit 5 selects the float bank
	typedef logic [5:0] reg_addr_t;
	typedef logic [15:0] imm_t;
	typedef logic [31:0] word_t;
	typedef logic [NUM_REGS-1:0] reg_mask_t;

	typedef enum logic [1:0] {
		op_int = 2'd0,
		op_mem = 2'd1,
		op_fpu = 2'd2
	} op_class_t;

	// r0 of the integer and the float bank
	localparam reg_mask_t ZERO_MASK = reg_mask_t'({31'b0, 1'b1, 31'b0, 1'b1});

endpackage

/* source/core_pkg.sv */
package core_pkg;

	localparam int WIN_DEPTH = 3;
	localparam int NUM_LANES = 3;
	localparam int DISP_WIDTH = 2;

	localparam int LANE_INT = 0;
	localparam int LANE_MEM = 1;
	localparam int LANE_FPU = 2;

	// one-hot refill source of a window slot
	localparam int SRC_HOLD = 0;
	localparam int SRC_NEXT = 1;
	localparam int SRC_AFTER = 2;
	localparam int SRC_DISP0 = 3;
	localparam int SRC_DISP1 = 4;
	localparam int SRC_EMPTY = 5;
	typedef logic [SRC_EMPTY:0] slot_sel_t;

endpackage

/* source/dispatch_buffer.sv */
`timescale 1ns/1ns

module dispatch_buffer (
	input logic clk,
	input logic rstn,
	input logic [core_pkg::DISP_WIDTH-1:0] i_op_valid,
	input isa_pkg::op_class_t i_op_class [core_pkg::DISP_WIDTH],
	input isa_pkg::reg_addr_t i_op_ds [core_pkg::DISP_WIDTH],
	input isa_pkg::reg_addr_t i_op_dt [core_pkg::DISP_WIDTH],
	input isa_pkg::reg_addr_t i_op_dd [core_pkg::DISP_WIDTH],
	input isa_pkg::imm_t i_op_imm [core_pkg::DISP_WIDTH],
	input logic [core_pkg::WIN_DEPTH-1:0] i_slot_valid,
	input logic [core_pkg::WIN_DEPTH-1:0] i_issued,
	output logic o_stall,
	output logic [core_pkg::DISP_WIDTH-1:0] o_disp_valid,
	output isa_pkg::op_class_t o_disp_class [core_pkg::DISP_WIDTH],
	output isa_pkg::reg_addr_t o_disp_ds [core_pkg::DISP_WIDTH],
	output isa_pkg::reg_addr_t o_disp_dt [core_pkg::DISP_WIDTH],
	output isa_pkg::reg_addr_t o_disp_dd [core_pkg::DISP_WIDTH],
	output isa_pkg::imm_t o_disp_imm [core_pkg::DISP_WIDTH],
	output core_pkg::slot_sel_t o_slot_sel [core_pkg::WIN_DEPTH]
);

	logic [core_pkg::WIN_DEPTH-1:0] exist;
	logic stall;
	logic was_stall;
	logic [core_pkg::DISP_WIDTH-1:0] held_valid;
	isa_pkg::op_class_t held_class [core_pkg::DISP_WIDTH];
	isa_pkg::reg_addr_t held_ds [core_pkg::DISP_WIDTH];
	isa_pkg::reg_addr_t held_dt [core_pkg::DISP_WIDTH];
	isa_pkg::reg_addr_t held_dd [core_pkg::DISP_WIDTH];
	isa_pkg::imm_t held_imm [core_pkg::DISP_WIDTH];

	// entries still waiting after this cycle's issue
	assign exist = i_slot_valid & ~i_issued;
	// two survivors leave no room for a whole pair
	assign stall = $countones(exist) >= 2;
	assign o_stall = stall;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			was_stall <= 1'b0;
			held_valid <= '0;
			o_disp_valid <= '0;
		end else begin
			was_stall <= stall;
			if (stall && !was_stall) begin
				held_valid <= i_op_valid;
			end
			if (!stall) begin
				o_disp_valid <= was_stall ? held_valid : i_op_valid;
			end
		end
	end

	// pair arriving on the first stall cycle is parked, replayed when stall drops
	always_ff @(posedge clk) begin
		for (int d = 0; d < core_pkg::DISP_WIDTH; d++) begin
			if (stall && !was_stall) begin
				held_class[d] <= i_op_class[d];
				held_ds[d] <= i_op_ds[d];
				held_dt[d] <= i_op_dt[d];
				held_dd[d] <= i_op_dd[d];
				held_imm[d] <= i_op_imm[d];
			end
			if (!stall) begin
				o_disp_class[d] <= was_stall ? held_class[d] : i_op_class[d];
				o_disp_ds[d] <= was_stall ? held_ds[d] : i_op_ds[d];
				o_disp_dt[d] <= was_stall ? held_dt[d] : i_op_dt[d];
				o_disp_dd[d] <= was_stall ? held_dd[d] : i_op_dd[d];
				o_disp_imm[d] <= was_stall ? held_imm[d] : i_op_imm[d];
			end
		end
	end

	// compact survivors toward slot 0, then append the pair
	always_comb begin
		int pos;
		pos = 0;
		for (int k = 0; k < core_pkg::WIN_DEPTH; k++) begin
			o_slot_sel[k] = core_pkg::slot_sel_t'(1) << core_pkg::SRC_EMPTY;
		end
		for (int j = 0; j < core_pkg::WIN_DEPTH; j++) begin
			if (exist[j]) begin
				// distance 0, 1, 2 is hold, next, after
				o_slot_sel[pos] = core_pkg::slot_sel_t'(1) << (core_pkg::SRC_HOLD + j - pos);
				pos++;
			end
		end
		if (!stall) begin
			for (int d = 0; d < core_pkg::DISP_WIDTH; d++) begin
				if (o_disp_valid[d]) begin
					o_slot_sel[pos] = core_pkg::slot_sel_t'(1) << (core_pkg::SRC_DISP0 + d);
					pos++;
				end
			end
		end
	end

endmodule

/* source/wait_slot.sv */
`timescale 1ns/1ns

module wait_slot (
	input logic clk,
	input logic rstn,
	input core_pkg::slot_sel_t i_sel,
	input logic i_next_valid,
	input isa_pkg::op_class_t i_next_class,
	input isa_pkg::reg_addr_t i_next_ds,
	input isa_pkg::reg_addr_t i_next_dt,
	input isa_pkg::reg_addr_t i_next_dd,
	input isa_pkg::imm_t i_next_imm,
	input logic i_after_valid,
	input isa_pkg::op_class_t i_after_class,
	input isa_pkg::reg_addr_t i_after_ds,
	input isa_pkg::reg_addr_t i_after_dt,
	input isa_pkg::reg_addr_t i_after_dd,
	input isa_pkg::imm_t i_after_imm,
	input logic [core_pkg::DISP_WIDTH-1:0] i_disp_valid,
	input isa_pkg::op_class_t i_disp_class [core_pkg::DISP_WIDTH],
	input isa_pkg::reg_addr_t i_disp_ds [core_pkg::DISP_WIDTH],
	input isa_pkg::reg_addr_t i_disp_dt [core_pkg::DISP_WIDTH],
	input isa_pkg::reg_addr_t i_disp_dd [core_pkg::DISP_WIDTH],
	input isa_pkg::imm_t i_disp_imm [core_pkg::DISP_WIDTH],
	output logic o_valid,
	output isa_pkg::op_class_t o_class,
	output isa_pkg::reg_addr_t o_ds,
	output isa_pkg::reg_addr_t o_dt,
	output isa_pkg::reg_addr_t o_dd,
	output isa_pkg::imm_t o_imm,
	output isa_pkg::reg_mask_t o_read_mask,
	output isa_pkg::reg_mask_t o_write_mask
);

	always_ff @(posedge clk) begin
		if (!rstn) begin
			o_valid <= 1'b0;
		end else if (i_sel[core_pkg::SRC_NEXT]) begin
			o_valid <= i_next_valid;
		end else if (i_sel[core_pkg::SRC_AFTER]) begin
			o_valid <= i_after_valid;
		end else if (i_sel[core_pkg::SRC_DISP0]) begin
			o_valid <= i_disp_valid[0];
		end else if (i_sel[core_pkg::SRC_DISP1]) begin
			o_valid <= i_disp_valid[1];
		end else if (i_sel[core_pkg::SRC_EMPTY]) begin
			o_valid <= 1'b0;
		end
	end

	// hold and empty keep the old fields
	always_ff @(posedge clk) begin
		if (i_sel[core_pkg::SRC_NEXT]) begin
			o_class <= i_next_class;
			o_ds <= i_next_ds;
			o_dt <= i_next_dt;
			o_dd <= i_next_dd;
			o_imm <= i_next_imm;
		end else if (i_sel[core_pkg::SRC_AFTER]) begin
			o_class <= i_after_class;
			o_ds <= i_after_ds;
			o_dt <= i_after_dt;
			o_dd <= i_after_dd;
			o_imm <= i_after_imm;
		end else if (i_sel[core_pkg::SRC_DISP0]) begin
			o_class <= i_disp_class[0];
			o_ds <= i_disp_ds[0];
			o_dt <= i_disp_dt[0];
			o_dd <= i_disp_dd[0];
			o_imm <= i_disp_imm[0];
		end else if (i_sel[core_pkg::SRC_DISP1]) begin
			o_class <= i_disp_class[1];
			o_ds <= i_disp_ds[1];
			o_dt <= i_disp_dt[1];
			o_dd <= i_disp_dd[1];
			o_imm <= i_disp_imm[1];
		end
	end

	// r0 never takes part in a dependency
	assign o_read_mask = o_valid ?
		((isa_pkg::reg_mask_t'(1) << o_ds) | (isa_pkg::reg_mask_t'(1) << o_dt))
		& ~isa_pkg::ZERO_MASK : '0;
	assign o_write_mask = o_valid ?
		(isa_pkg::reg_mask_t'(1) << o_dd) & ~isa_pkg::ZERO_MASK : '0;

endmodule

/* source/issue_select.sv */
`timescale 1ns/1ns

module issue_select (
	input logic clk,
	input logic rstn,
	input logic [core_pkg::WIN_DEPTH-1:0] i_slot_valid,
	input isa_pkg::op_class_t i_slot_class [core_pkg::WIN_DEPTH],
	input isa_pkg::reg_mask_t i_slot_read_mask [core_pkg::WIN_DEPTH],
	input isa_pkg::reg_mask_t i_slot_write_mask [core_pkg::WIN_DEPTH],
	input isa_pkg::reg_addr_t i_slot_dd [core_pkg::WIN_DEPTH],
	input isa_pkg::imm_t i_slot_imm [core_pkg::WIN_DEPTH],
	input isa_pkg::word_t i_slot_ds_val [core_pkg::WIN_DEPTH],
	input isa_pkg::word_t i_slot_dt_val [core_pkg::WIN_DEPTH],
	input isa_pkg::reg_mask_t i_board,
	output logic [core_pkg::WIN_DEPTH-1:0] o_lane_grant [core_pkg::NUM_LANES],
	output logic [core_pkg::WIN_DEPTH-1:0] o_issued,
	output isa_pkg::reg_mask_t o_issue_write_mask,
	output logic [core_pkg::NUM_LANES-1:0] o_lane_valid,
	output isa_pkg::op_class_t o_lane_class [core_pkg::NUM_LANES],
	output isa_pkg::word_t o_lane_ds_val [core_pkg::NUM_LANES],
	output isa_pkg::word_t o_lane_dt_val [core_pkg::NUM_LANES],
	output isa_pkg::reg_addr_t o_lane_dd [core_pkg::NUM_LANES],
	output isa_pkg::imm_t o_lane_imm [core_pkg::NUM_LANES]
);

	logic [core_pkg::WIN_DEPTH-1:0] ready;
	logic [core_pkg::WIN_DEPTH-1:0] grant [core_pkg::NUM_LANES];

	// slot 0 is the oldest
	always_comb begin
		isa_pkg::reg_mask_t older_write;
		isa_pkg::reg_mask_t older_read;
		isa_pkg::reg_mask_t use_mask;
		older_write = '0;
		older_read = '0;
		for (int s = 0; s < core_pkg::WIN_DEPTH; s++) begin
			use_mask = i_slot_read_mask[s] | i_slot_write_mask[s];
			ready[s] = i_slot_valid[s]
				&& ((i_board | older_write) & use_mask) == '0
				&& (i_slot_write_mask[s] & older_read) == '0;
			older_write = older_write | i_slot_write_mask[s];
			older_read = older_read | i_slot_read_mask[s];
		end
	end

	always_comb begin
		logic mem_seen;
		mem_seen = 1'b0;
		for (int l = 0; l < core_pkg::NUM_LANES; l++) begin
			grant[l] = '0;
		end
		// memory goes strictly in order
		for (int s = 0; s < core_pkg::WIN_DEPTH; s++) begin
			if (i_slot_valid[s] && i_slot_class[s] == isa_pkg::op_mem && !mem_seen) begin
				mem_seen = 1'b1;
				grant[core_pkg::LANE_MEM][s] = ready[s];
			end
		end
		// float claims lane 2 before integer overflow does
		for (int s = 0; s < core_pkg::WIN_DEPTH; s++) begin
			if (ready[s] && i_slot_class[s] == isa_pkg::op_fpu
				&& grant[core_pkg::LANE_FPU] == '0) begin
				grant[core_pkg::LANE_FPU][s] = 1'b1;
			end
		end
		for (int s = 0; s < core_pkg::WIN_DEPTH; s++) begin
			if (ready[s] && i_slot_class[s] == isa_pkg::op_int) begin
				if (grant[core_pkg::LANE_INT] == '0) begin
					grant[core_pkg::LANE_INT][s] = 1'b1;
				end else if (grant[core_pkg::LANE_FPU] == '0) begin
					grant[core_pkg::LANE_FPU][s] = 1'b1;
				end
			end
		end
	end

	assign o_lane_grant = grant;
	assign o_issued = grant[core_pkg::LANE_INT] | grant[core_pkg::LANE_MEM]
		| grant[core_pkg::LANE_FPU];

	always_comb begin
		o_issue_write_mask = '0;
		for (int s = 0; s < core_pkg::WIN_DEPTH; s++) begin
			if (o_issued[s]) begin
				o_issue_write_mask = o_issue_write_mask | i_slot_write_mask[s];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			o_lane_valid <= '0;
		end else begin
			for (int l = 0; l < core_pkg::NUM_LANES; l++) begin
				o_lane_valid[l] <= |grant[l];
			end
		end
	end

	// payload only meaningful with o_lane_valid
	always_ff @(posedge clk) begin
		for (int l = 0; l < core_pkg::NUM_LANES; l++) begin
			for (int s = 0; s < core_pkg::WIN_DEPTH; s++) begin
				if (grant[l][s]) begin
					o_lane_class[l] <= i_slot_class[s];
					o_lane_ds_val[l] <= i_slot_ds_val[s];
					o_lane_dt_val[l] <= i_slot_dt_val[s];
					o_lane_dd[l] <= i_slot_dd[s];
					o_lane_imm[l] <= i_slot_imm[s];
				end
			end
		end
	end

endmodule

/* source/reg_scoreboard.sv */
`timescale 1ns/1ns

module reg_scoreboard (
	input logic clk,
	input logic rstn,
	input isa_pkg::reg_addr_t i_rd_addr [2*core_pkg::WIN_DEPTH],
	input isa_pkg::reg_mask_t i_issue_write_mask,
	input logic [core_pkg::NUM_LANES-1:0] i_wb_valid,
	input isa_pkg::reg_addr_t i_wb_addr [core_pkg::NUM_LANES],
	input isa_pkg::word_t i_wb_data [core_pkg::NUM_LANES],
	output isa_pkg::word_t o_rd_data [2*core_pkg::WIN_DEPTH],
	output isa_pkg::reg_mask_t o_board
);

	isa_pkg::word_t regfile [isa_pkg::NUM_REGS];
	logic [core_pkg::NUM_LANES-1:0] stg_valid;
	isa_pkg::reg_addr_t stg_addr [core_pkg::NUM_LANES];
	isa_pkg::word_t stg_data [core_pkg::NUM_LANES];
	logic [core_pkg::NUM_LANES-1:0] wb_keep;
	isa_pkg::reg_mask_t wb_clear;

	// writes to r0 of either bank are dropped
	always_comb begin
		wb_clear = '0;
		for (int l = 0; l < core_pkg::NUM_LANES; l++) begin
			wb_keep[l] = i_wb_valid[l] && i_wb_addr[l][4:0] != 5'd0;
			if (wb_keep[l]) begin
				wb_clear = wb_clear | (isa_pkg::reg_mask_t'(1) << i_wb_addr[l]);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			o_board <= '0;
			stg_valid <= '0;
		end else begin
			o_board <= ((o_board & ~wb_clear) | i_issue_write_mask) & ~isa_pkg::ZERO_MASK;
			stg_valid <= wb_keep;
		end
	end

	always_ff @(posedge clk) begin
		for (int l = 0; l < core_pkg::NUM_LANES; l++) begin
			stg_addr[l] <= i_wb_addr[l];
			stg_data[l] <= i_wb_data[l];
		end
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			for (int r = 0; r < isa_pkg::NUM_REGS; r++) begin
				regfile[r] <= '0;
			end
		end else begin
			for (int l = 0; l < core_pkg::NUM_LANES; l++) begin
				if (stg_valid[l]) begin
					regfile[stg_addr[l]] <= stg_data[l];
				end
			end
		end
	end

	// staging is newer than the file
	function automatic isa_pkg::word_t read_port(input isa_pkg::reg_addr_t addr);
		isa_pkg::word_t val;
		val = regfile[addr];
		for (int l = 0; l < core_pkg::NUM_LANES; l++) begin
			if (stg_valid[l] && stg_addr[l] == addr) begin
				val = stg_data[l];
			end
		end
		if (addr[4:0] == 5'd0) begin
			val = '0;
		end
		return val;
	endfunction

	always_comb begin
		for (int p = 0; p < 2*core_pkg::WIN_DEPTH; p++) begin
			o_rd_data[p] = read_port(i_rd_addr[p]);
		end
	end

endmodule

/* source/issue_core.sv */
`timescale 1ns/1ns

module issue_core (
	input logic clk,
	input logic rstn,
	input logic [core_pkg::DISP_WIDTH-1:0] i_op_valid,
	input isa_pkg::op_class_t i_op_class [core_pkg::DISP_WIDTH],
	input isa_pkg::reg_addr_t i_op_ds [core_pkg::DISP_WIDTH],
	input isa_pkg::reg_addr_t i_op_dt [core_pkg::DISP_WIDTH],
	input isa_pkg::reg_addr_t i_op_dd [core_pkg::DISP_WIDTH],
	input isa_pkg::imm_t i_op_imm [core_pkg::DISP_WIDTH],
	output logic o_stall,
	output logic [core_pkg::NUM_LANES-1:0] o_lane_valid,
	output isa_pkg::op_class_t o_lane_class [core_pkg::NUM_LANES],
	output isa_pkg::word_t o_lane_ds_val [core_pkg::NUM_LANES],
	output isa_pkg::word_t o_lane_dt_val [core_pkg::NUM_LANES],
	output isa_pkg::reg_addr_t o_lane_dd [core_pkg::NUM_LANES],
	output isa_pkg::imm_t o_lane_imm [core_pkg::NUM_LANES],
	input logic [core_pkg::NUM_LANES-1:0] i_wb_valid,
	input isa_pkg::reg_addr_t i_wb_addr [core_pkg::NUM_LANES],
	input isa_pkg::word_t i_wb_data [core_pkg::NUM_LANES]
);

	localparam int W = core_pkg::WIN_DEPTH;

	logic [core_pkg::DISP_WIDTH-1:0] disp_valid;
	isa_pkg::op_class_t disp_class [core_pkg::DISP_WIDTH];
	isa_pkg::reg_addr_t disp_ds [core_pkg::DISP_WIDTH];
	isa_pkg::reg_addr_t disp_dt [core_pkg::DISP_WIDTH];
	isa_pkg::reg_addr_t disp_dd [core_pkg::DISP_WIDTH];
	isa_pkg::imm_t disp_imm [core_pkg::DISP_WIDTH];
	core_pkg::slot_sel_t slot_sel [W];
	logic [W-1:0] slot_valid;
	isa_pkg::op_class_t slot_class [W];
	isa_pkg::reg_addr_t slot_ds [W];
	isa_pkg::reg_addr_t slot_dt [W];
	isa_pkg::reg_addr_t slot_dd [W];
	isa_pkg::imm_t slot_imm [W];
	isa_pkg::reg_mask_t slot_read_mask [W];
	isa_pkg::reg_mask_t slot_write_mask [W];
	isa_pkg::word_t slot_ds_val [W];
	isa_pkg::word_t slot_dt_val [W];
	isa_pkg::reg_addr_t rd_addr [2*W];
	isa_pkg::word_t rd_data [2*W];
	logic [W-1:0] issued;
	isa_pkg::reg_mask_t issue_write_mask;
	isa_pkg::reg_mask_t board;

	dispatch_buffer u_disp (
		.clk(clk),
		.rstn(rstn),
		.i_op_valid(i_op_valid),
		.i_op_class(i_op_class),
		.i_op_ds(i_op_ds),
		.i_op_dt(i_op_dt),
		.i_op_dd(i_op_dd),
		.i_op_imm(i_op_imm),
		.i_slot_valid(slot_valid),
		.i_issued(issued),
		.o_stall(o_stall),
		.o_disp_valid(disp_valid),
		.o_disp_class(disp_class),
		.o_disp_ds(disp_ds),
		.o_disp_dt(disp_dt),
		.o_disp_dd(disp_dd),
		.o_disp_imm(disp_imm),
		.o_slot_sel(slot_sel)
	);

	for (genvar i = 0; i < W; i++) begin : g_slot
		// last slots wrap around here, the refill never selects those sources
		wait_slot u_slot (
			.clk(clk),
			.rstn(rstn),
			.i_sel(slot_sel[i]),
			.i_next_valid(slot_valid[(i + 1) % W]),
			.i_next_class(slot_class[(i + 1) % W]),
			.i_next_ds(slot_ds[(i + 1) % W]),
			.i_next_dt(slot_dt[(i + 1) % W]),
			.i_next_dd(slot_dd[(i + 1) % W]),
			.i_next_imm(slot_imm[(i + 1) % W]),
			.i_after_valid(slot_valid[(i + 2) % W]),
			.i_after_class(slot_class[(i + 2) % W]),
			.i_after_ds(slot_ds[(i + 2) % W]),
			.i_after_dt(slot_dt[(i + 2) % W]),
			.i_after_dd(slot_dd[(i + 2) % W]),
			.i_after_imm(slot_imm[(i + 2) % W]),
			.i_disp_valid(disp_valid),
			.i_disp_class(disp_class),
			.i_disp_ds(disp_ds),
			.i_disp_dt(disp_dt),
			.i_disp_dd(disp_dd),
			.i_disp_imm(disp_imm),
			.o_valid(slot_valid[i]),
			.o_class(slot_class[i]),
			.o_ds(slot_ds[i]),
			.o_dt(slot_dt[i]),
			.o_dd(slot_dd[i]),
			.o_imm(slot_imm[i]),
			.o_read_mask(slot_read_mask[i]),
			.o_write_mask(slot_write_mask[i])
		);

		// even read port is ds, odd is dt
		assign rd_addr[2*i] = slot_ds[i];
		assign rd_addr[2*i+1] = slot_dt[i];
		assign slot_ds_val[i] = rd_data[2*i];
		assign slot_dt_val[i] = rd_data[2*i+1];
	end

	issue_select u_sel (
		.clk(clk),
		.rstn(rstn),
		.i_slot_valid(slot_valid),
		.i_slot_class(slot_class),
		.i_slot_read_mask(slot_read_mask),
		.i_slot_write_mask(slot_write_mask),
		.i_slot_dd(slot_dd),
		.i_slot_imm(slot_imm),
		.i_slot_ds_val(slot_ds_val),
		.i_slot_dt_val(slot_dt_val),
		.i_board(board),
		.o_lane_grant(),
		.o_issued(issued),
		.o_issue_write_mask(issue_write_mask),
		.o_lane_valid(o_lane_valid),
		.o_lane_class(o_lane_class),
		.o_lane_ds_val(o_lane_ds_val),
		.o_lane_dt_val(o_lane_dt_val),
		.o_lane_dd(o_lane_dd),
		.o_lane_imm(o_lane_imm)
	);

	reg_scoreboard u_regs (
		.clk(clk),
		.rstn(rstn),
		.i_rd_addr(rd_addr),
		.i_issue_write_mask(issue_write_mask),
		.i_wb_valid(i_wb_valid),
		.i_wb_addr(i_wb_addr),
		.i_wb_data(i_wb_data),
		.o_rd_data(rd_data),
		.o_board(board)
	);

endmodule

/* tb/issue_checker.sv */
`timescale 1ns/1ns

module issue_checker #(
	parameter int NUM_OPS = 22
) (
	input logic clk,
	input logic rstn,
	input logic [31:0] i_golden [NUM_OPS*7],
	input logic i_stall,
	input logic [core_pkg::NUM_LANES-1:0] i_lane_valid,
	input isa_pkg::op_class_t i_lane_class [core_pkg::NUM_LANES],
	input isa_pkg::word_t i_lane_ds_val [core_pkg::NUM_LANES],
	input isa_pkg::word_t i_lane_dt_val [core_pkg::NUM_LANES],
	input isa_pkg::reg_addr_t i_lane_dd [core_pkg::NUM_LANES],
	input isa_pkg::imm_t i_lane_imm [core_pkg::NUM_LANES],
	input logic [core_pkg::NUM_LANES-1:0] i_wb_valid,
	input isa_pkg::reg_addr_t i_wb_addr [core_pkg::NUM_LANES],
	output int o_errors,
	output int o_checks,
	output int o_issued
);

	int errors = 0;
	int checks = 0;
	int issued = 0;
	int mem_count = 0;
	bit seen [NUM_OPS];
	isa_pkg::reg_mask_t pend = '0;
	isa_pkg::reg_mask_t wb_seen = '0;

	assign o_errors = errors;
	assign o_checks = checks;
	assign o_issued = issued;

	task automatic fail_check(input string msg);
		$display("FAILED at %0t ns: %s", $time, msg);
		errors++;
	endtask

	function automatic int find_op(input isa_pkg::imm_t tag);
		for (int i = 0; i < NUM_OPS; i++) begin
			if (i_golden[i*7+4][15:0] == tag) begin
				return i;
			end
		end
		return -1;
	endfunction

	// index of the n-th memory op in program order
	function automatic int nth_mem(input int n);
		int cnt;
		cnt = 0;
		for (int i = 0; i < NUM_OPS; i++) begin
			if (i_golden[i*7][1:0] == 2'd1) begin
				if (cnt == n) begin
					return i;
				end
				cnt++;
			end
		end
		return -1;
	endfunction

	function automatic bit lane_allowed(input int cls, input int lane);
		case (cls)
			0: return lane == core_pkg::LANE_INT || lane == core_pkg::LANE_FPU;
			1: return lane == core_pkg::LANE_MEM;
			2: return lane == core_pkg::LANE_FPU;
			default: return 1'b0;
		endcase
	endfunction

	function automatic bit is_pending(input isa_pkg::reg_addr_t addr);
		return addr[4:0] != 5'd0 && pend[addr];
	endfunction

	task automatic compare_word(input string what, input int idx, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			fail_check($sformatf("op %0d %s is %0h, expected %0h", idx + 1, what, got, exp));
		end
	endtask

	task automatic check_issue(input int l);
		int idx;
		int cls;
		idx = find_op(i_lane_imm[l]);
		if (idx < 0) begin
			fail_check($sformatf("lane %0d issued unknown tag %0h", l, i_lane_imm[l]));
			return;
		end
		checks++;
		if (seen[idx]) begin
			fail_check($sformatf("op %0d issued twice", idx + 1));
		end else begin
			seen[idx] = 1'b1;
			issued++;
		end
		cls = int'(i_golden[idx*7][1:0]);
		compare_word("class", idx, 32'(i_lane_class[l]), 32'(cls));
		checks++;
		if (!lane_allowed(cls, l)) begin
			fail_check($sformatf("op %0d of class %0d on lane %0d", idx + 1, cls, l));
		end
		compare_word("ds value", idx, i_lane_ds_val[l], i_golden[idx*7+5]);
		compare_word("dt value", idx, i_lane_dt_val[l], i_golden[idx*7+6]);
		compare_word("dd", idx, 32'(i_lane_dd[l]), 32'(i_golden[idx*7+3][5:0]));
		if (cls == 1) begin
			checks++;
			if (idx != nth_mem(mem_count)) begin
				fail_check($sformatf("memory op %0d out of order", idx + 1));
			end
			mem_count++;
		end
		// source must not still be waiting for its writeback
		checks++;
		if (is_pending(i_golden[idx*7+1][5:0]) || is_pending(i_golden[idx*7+2][5:0])) begin
			fail_check($sformatf("op %0d issued before its source was written", idx + 1));
		end
	endtask

	always @(posedge clk) begin
		wb_seen = '0;
		for (int l = 0; l < core_pkg::NUM_LANES; l++) begin
			if (i_wb_valid[l] && i_wb_addr[l][4:0] != 5'd0) begin
				wb_seen[i_wb_addr[l]] = 1'b1;
			end
		end
	end

	// lane outputs are registered, stable here
	always @(negedge clk) begin
		pend = pend & ~wb_seen;
		if (!rstn) begin
			if (i_lane_valid != '0) begin
				fail_check("lane valid during reset");
			end
			if (i_stall) begin
				fail_check("stall during reset");
			end
		end else begin
			for (int l = 0; l < core_pkg::NUM_LANES; l++) begin
				if (i_lane_valid[l]) begin
					check_issue(l);
				end
			end
			// every op has left the window
			if (issued == NUM_OPS) begin
				checks++;
				if (i_stall) begin
					fail_check("stall raised with an empty window");
				end
			end
			for (int l = 0; l < core_pkg::NUM_LANES; l++) begin
				if (i_lane_valid[l] && i_lane_dd[l][4:0] != 5'd0) begin
					pend[i_lane_dd[l]] = 1'b1;
				end
			end
		end
	end

endmodule

/* tb/tb_issue_core.sv */
`timescale 1ns/1ns

module tb_issue_core;

	localparam int NUM_OPS = 22;
	localparam int QD = 16;
	localparam int NL = core_pkg::NUM_LANES;

	logic clk;
	logic rstn;
	logic [1:0] op_valid;
	isa_pkg::op_class_t op_class [2];
	isa_pkg::reg_addr_t op_ds [2];
	isa_pkg::reg_addr_t op_dt [2];
	isa_pkg::reg_addr_t op_dd [2];
	isa_pkg::imm_t op_imm [2];
	logic stall;
	logic [NL-1:0] lane_valid;
	isa_pkg::op_class_t lane_class [NL];
	isa_pkg::word_t lane_ds_val [NL];
	isa_pkg::word_t lane_dt_val [NL];
	isa_pkg::reg_addr_t lane_dd [NL];
	isa_pkg::imm_t lane_imm [NL];
	logic [NL-1:0] wb_valid = '0;
	isa_pkg::reg_addr_t wb_addr [NL] = '{default: '0};
	isa_pkg::word_t wb_data [NL] = '{default: '0};
	logic [31:0] golden [NUM_OPS*7];
	int errors;
	int checks;
	int issued;

	// per-lane writeback queues of the execution units
	int cycle = 0;
	int q_head [NL] = '{default: 0};
	int q_tail [NL] = '{default: 0};
	int last_due [NL] = '{default: 0};
	int q_due [NL][QD];
	isa_pkg::reg_addr_t q_addr [NL][QD];
	isa_pkg::word_t q_data [NL][QD];

	issue_core u_dut (
		.clk(clk),
		.rstn(rstn),
		.i_op_valid(op_valid),
		.i_op_class(op_class),
		.i_op_ds(op_ds),
		.i_op_dt(op_dt),
		.i_op_dd(op_dd),
		.i_op_imm(op_imm),
		.o_stall(stall),
		.o_lane_valid(lane_valid),
		.o_lane_class(lane_class),
		.o_lane_ds_val(lane_ds_val),
		.o_lane_dt_val(lane_dt_val),
		.o_lane_dd(lane_dd),
		.o_lane_imm(lane_imm),
		.i_wb_valid(wb_valid),
		.i_wb_addr(wb_addr),
		.i_wb_data(wb_data)
	);

	issue_checker #(.NUM_OPS(NUM_OPS)) u_chk (
		.clk(clk),
		.rstn(rstn),
		.i_golden(golden),
		.i_stall(stall),
		.i_lane_valid(lane_valid),
		.i_lane_class(lane_class),
		.i_lane_ds_val(lane_ds_val),
		.i_lane_dt_val(lane_dt_val),
		.i_lane_dd(lane_dd),
		.i_lane_imm(lane_imm),
		.i_wb_valid(wb_valid),
		.i_wb_addr(wb_addr),
		.o_errors(errors),
		.o_checks(checks),
		.o_issued(issued)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic drive_idle();
		op_valid = '0;
		for (int d = 0; d < 2; d++) begin
			op_class[d] = isa_pkg::op_int;
			op_ds[d] = '0;
			op_dt[d] = '0;
			op_dd[d] = '0;
			op_imm[d] = '0;
		end
	endtask

	task automatic drive_pair(input int first);
		int idx;
		for (int d = 0; d < 2; d++) begin
			idx = first + d;
			op_valid[d] = 1'b1;
			op_class[d] = isa_pkg::op_class_t'(golden[idx*7][1:0]);
			op_ds[d] = golden[idx*7+1][5:0];
			op_dt[d] = golden[idx*7+2][5:0];
			op_dd[d] = golden[idx*7+3][5:0];
			op_imm[d] = golden[idx*7+4][15:0];
		end
	endtask

	function automatic bit units_idle();
		for (int l = 0; l < NL; l++) begin
			if (q_head[l] != q_tail[l]) begin
				return 1'b0;
			end
		end
		return 1'b1;
	endfunction

	task automatic print_counts();
		$display("checks %0d, errors %0d, issued %0d of %0d", checks, errors, issued, NUM_OPS);
	endtask

	// execution units: result is ds + dt + imm after 1 to 3 cycles
	always @(negedge clk) begin
		int due;
		int pos;
		cycle++;
		for (int l = 0; l < NL; l++) begin
			if (rstn && lane_valid[l]) begin
				due = cycle + int'($urandom_range(3, 1));
				if (due <= last_due[l]) begin
					due = last_due[l] + 1;
				end
				last_due[l] = due;
				pos = q_tail[l] % QD;
				q_due[l][pos] = due;
				q_addr[l][pos] = lane_dd[l];
				q_data[l][pos] = lane_ds_val[l] + lane_dt_val[l] + 32'(lane_imm[l]);
				q_tail[l]++;
			end
			pos = q_head[l] % QD;
			if (q_head[l] != q_tail[l] && q_due[l][pos] <= cycle) begin
				wb_valid[l] = 1'b1;
				wb_addr[l] = q_addr[l][pos];
				wb_data[l] = q_data[l][pos];
				q_head[l]++;
			end else begin
				wb_valid[l] = 1'b0;
			end
		end
	end

	initial begin
		bit prev_stall;
		int next;
		void'($urandom(31));
		rstn = 1'b0;
		drive_idle();
		$readmemh("tb/golden_ops.txt", golden);
		repeat (4) @(posedge clk);
		@(negedge clk);
		rstn = 1'b1;
		prev_stall = 1'b0;
		next = 0;
		// new pair only after a cycle without stall, otherwise hold
		while (next < NUM_OPS) begin
			@(negedge clk);
			if (!prev_stall) begin
				if ($urandom_range(3, 0) == 0) begin
					drive_idle();
				end else begin
					drive_pair(next);
					next += 2;
				end
			end
			prev_stall = stall;
		end
		// last pair stays until a cycle without stall
		@(negedge clk);
		while (prev_stall) begin
			prev_stall = stall;
			@(negedge clk);
		end
		drive_idle();
		wait (issued == NUM_OPS);
		while (!units_idle()) begin
			@(negedge clk);
		end
		repeat (4) @(negedge clk);
		print_counts();
		if (errors == 0 && issued == NUM_OPS) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

	initial begin
		repeat (40 * NUM_OPS + 100) @(posedge clk);
		$display("timeout: not every operation issued before the time limit");
		print_counts();
		$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

/* build.f */
source/isa_pkg.sv
source/core_pkg.sv
source/dispatch_buffer.sv
source/wait_slot.sv
source/issue_select.sv
source/reg_scoreboard.sv
source/issue_core.sv
tb/issue_checker.sv
tb/tb_issue_core.sv

/* Makefile */
SRCS := $(wildcard source/*.sv tb/*.sv)

obj_dir/Vtb_issue_core: build.f $(SRCS)
	verilator --binary --timing -Wno-fatal --top-module tb_issue_core -f build.f

run: obj_dir/Vtb_issue_core tb/golden_ops.txt
	./obj_dir/Vtb_issue_core | tee sim.log
	grep -q "ALL TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

/* tb/golden_ops.txt */
// class ds dt dd tag expected_ds expected_dt
// class 0 int, 1 mem, 2 fpu; registers 20 and up are the float bank
0 00 00 01 0001 00000000 00000000
0 00 00 02 0002 00000000 00000000
0 01 02 03 0003 00000001 00000002
2 20 21 21 0004 00000000 00000000
1 03 00 04 0005 00000006 00000000
2 21 21 22 0006 00000004 00000004
0 04 01 01 0007 0000000b 00000001
1 01 03 05 0008 00000013 00000006
0 02 02 00 0009 00000002 00000002
2 22 21 21 000a 0000000e 00000004
0 00 05 06 000b 00000000 00000021
1 06 04 00 000c 0000002c 0000000b
0 06 06 07 000d 0000002c 0000002c
2 21 22 23 000e 0000001c 0000000e
0 07 01 02 000f 00000065 00000013
1 02 07 08 0010 00000087 00000065
0 08 00 03 0011 000000fc 00000000
2 23 20 20 0012 00000038 00000000
0 03 08 09 0013 0000010d 000000fc
1 09 05 0a 0014 0000021c 00000021
2 23 23 24 0015 00000038 00000038
0 0a 09 01 0016 00000251 0000021c
